// ==== mc16_cpu.f ====
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/unified_memory.sv
rtl/memory_stage.sv
control/cycle_controller.sv
rtl/mc16_cpu.sv
verification/tb_clock_gen.sv
verification/tb_mc16_cpu.sv

// ==== Makefile ====
TOP = tb_mc16_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f mc16_cpu.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f mc16_cpu.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== verification/tb_mc16_cpu.sv ====
`timescale 1ns/10ps
`include "mc16_config.svh"

module tb_mc16_cpu;
    import isa_pkg::*;

    localparam int PROGRAM_COUNT = 4;
    localparam int RESET_CYCLES  = 10;
    localparam int HALT_HOLD     = 20;
    localparam int MAX_STEPS     = 1000;

    logic                      clock;
    logic                      rst_n;
    logic                      load_en;
    logic [`MEM_ADDR_BITS-1:0] load_addr;
    logic [`DATA_WIDTH-1:0]    load_data;
    logic [`DATA_WIDTH-1:0]    io_in;
    logic [`DATA_WIDTH-1:0]    io_out;
    logic                      io_strobe;
    logic                      halted;

    // ISA model
    logic [`DATA_WIDTH-1:0] m_reg [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] m_mem [2**`MEM_ADDR_BITS];
    logic [`DATA_WIDTH-1:0] m_pc;
    logic [`DATA_WIDTH-1:0] exp_q [$];
    logic [`DATA_WIDTH-1:0] program_words [$];

    logic                   checking;
    logic                   exp_strobe;
    logic                   exp_halted;
    logic [`DATA_WIDTH-1:0] exp_io_out;

    integer seed = 50428;
    int     step_limit;

    tb_clock_gen i_tb_clock_gen
    (
        .clock (clock)
    );

    mc16_cpu i_mc16_cpu
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .io_in     (io_in),
        .io_out    (io_out),
        .io_strobe (io_strobe),
        .halted    (halted)
    );

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        stop_with_failure($sformatf("mismatch at time %0t: %s", $time, what));
    endtask

    function automatic logic [`DATA_WIDTH-1:0] encode(input opcode_t op, input int rd,
                                                     input int rs1, input int low);
        return {op, rd[3:0], rs1[3:0], low[3:0]};
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] sign_extend(input logic [3:0] value);
        return {{(`DATA_WIDTH-4){value[3]}}, value};
    endfunction

    // ###########################################################################
    // Test programs, each short enough to load during one reset
    // ###########################################################################

    task automatic build_program(input int p);
        program_words.delete();
        case (p)
            0:
            begin
                program_words.push_back(encode(IN,  1, 0, 0));
                program_words.push_back(encode(IN,  2, 0, 0));
                program_words.push_back(encode(OUT, 0, 1, 0)); // Inputs in order
                program_words.push_back(encode(OUT, 0, 2, 0));
                program_words.push_back(encode(ADD, 3, 1, 2));
                program_words.push_back(encode(OUT, 0, 3, 0));
                program_words.push_back(encode(SUB, 4, 1, 2));
                program_words.push_back(encode(OUT, 0, 4, 0));
                program_words.push_back(encode(HALT, 0, 0, 0));
            end
            1:
            begin
                program_words.push_back(encode(IN,   1, 0, 0));
                program_words.push_back(encode(IN,   2, 0, 0));
                program_words.push_back(encode(AND,  3, 1, 2));
                program_words.push_back(encode(OUT,  0, 3, 0));
                program_words.push_back(encode(OR,   4, 1, 2));
                program_words.push_back(encode(OUT,  0, 4, 0));
                program_words.push_back(encode(ADDI, 5, 0, -1));
                program_words.push_back(encode(ADDI, 6, 5, 2)); // Wraps to 1
                program_words.push_back(encode(OUT,  0, 6, 0));
                program_words.push_back(encode(HALT, 0, 0, 0));
            end
            2:
            begin
                // Store through r2 + 2, load back through r4 - 2
                program_words.push_back(encode(IN,   1, 0, 0));
                program_words.push_back(encode(ADDI, 2, 0, 7));
                program_words.push_back(encode(ADDI, 2, 2, 7));
                program_words.push_back(encode(SW,   1, 2, 2));
                program_words.push_back(encode(ADDI, 4, 2, 4));
                program_words.push_back(encode(LW,   3, 4, -2));
                program_words.push_back(encode(OUT,  0, 3, 0));
                program_words.push_back(encode(HALT, 0, 0, 0));
            end
            default:
            begin
                program_words.push_back(encode(ADDI, 1, 0, 3));
                program_words.push_back(encode(OUT,  0, 1, 0));
                program_words.push_back(encode(ADDI, 1, 1, -1));
                program_words.push_back(encode(BEQ,  0, 1, 1));  // Leaves loop at zero
                program_words.push_back(encode(BEQ,  0, 0, -4)); // Back to the OUT
                program_words.push_back(encode(OUT,  0, 1, 0));
                program_words.push_back(encode(HALT, 0, 0, 0));
            end
        endcase
    endtask

    task automatic reset_and_load();
        @(negedge clock);
        rst_n = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            if (i < program_words.size())
            begin
                load_en   = 1'b1;
                load_addr = `MEM_ADDR_BITS'(i);
                load_data = program_words[i];
                m_mem[i]  = program_words[i];
            end
            else
                load_en = 1'b0;
            @(negedge clock);
        end
        load_en = 1'b0;
        rst_n   = 1'b1;
    endtask

    function automatic void reset_model();
        for (int i = 0; i < `REG_COUNT; i++)
            m_reg[i] = '0;
        m_pc = `DATA_WIDTH'(`RESET_PC);
    endfunction

    // Cycles from FETCH up to the edge where the instruction completes
    function automatic int cycles_for(input opcode_t op);
        case (op)
            ADD, SUB, AND, OR, ADDI, SW: return 4;
            LW:                          return 5;
            BEQ, IN, OUT:                return 3;
            default:                     return 2; // Parks after DECODE
        endcase
    endfunction

    // One instruction on the model, returns 1 when it halts
    function automatic bit model_step(input logic [`DATA_WIDTH-1:0] in_value, input bit record);
        instr_u                 ir;
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] imm;
        logic [`DATA_WIDTH-1:0] addr;
        ir   = m_mem[m_pc[`MEM_ADDR_BITS-1:0]];
        a    = m_reg[ir.r.rs1];
        b    = m_reg[ir.r.rs2];
        imm  = sign_extend(ir.i.imm4);
        addr = a + imm;
        m_pc = m_pc + 16'd1;
        case (ir.r.opcode)
            ADD:  m_reg[ir.r.rd] = a + b;
            SUB:  m_reg[ir.r.rd] = a - b;
            AND:  m_reg[ir.r.rd] = a & b;
            OR:   m_reg[ir.r.rd] = a | b;
            ADDI: m_reg[ir.r.rd] = addr;
            LW:   m_reg[ir.r.rd] = m_mem[addr[`MEM_ADDR_BITS-1:0]];
            SW:   m_mem[addr[`MEM_ADDR_BITS-1:0]] = m_reg[ir.r.rd];
            BEQ:
            begin
                if (a == m_reg[ir.r.rd])
                    m_pc = m_pc + imm;
            end
            IN:   m_reg[ir.r.rd] = in_value;
            OUT:
            begin
                if (record)
                    exp_q.push_back(a);
            end
            default:
                return 1'b1;
        endcase
        return 1'b0;
    endfunction

    function automatic int count_instructions();
        int count;
        bit stop;
        reset_model();
        count = 0;
        stop  = 1'b0;
        while (!stop && count < MAX_STEPS)
        begin
            stop  = model_step('0, 1'b0);
            count = count + 1;
        end
        return count;
    endfunction

    // Steps the model in step with the expected cycle counts
    task automatic run_model();
        bit stop;
        int cycles;
        int pending;
        reset_model();
        exp_strobe = 1'b0;
        exp_halted = 1'b0;
        exp_io_out = '0;
        stop       = 1'b0;
        while (!stop)
        begin
            cycles = cycles_for(opcode_t'(m_mem[m_pc[`MEM_ADDR_BITS-1:0]][15:12]));
            for (int c = 0; c < cycles; c++)
            begin
                @(posedge clock);
                checking   = 1'b1;
                exp_strobe = 1'b0;
            end
            pending = exp_q.size();
            stop    = model_step(io_in, 1'b1); // IN samples at this edge
            if (exp_q.size() > pending)
            begin
                exp_io_out = exp_q[$];
                exp_strobe = 1'b1;
            end
            if (stop)
                exp_halted = 1'b1;
        end
    endtask

    task automatic watch_for_halt(input int limit);
        int cycles;
        cycles = 0;
        while (halted !== 1'b1)
        begin
            @(negedge clock);
            cycles = cycles + 1;
            if (cycles > limit)
                stop_with_failure("timeout: processor never halted");
        end
    endtask

    // ###########################################################################
    // Checks against the model, sampled on the falling edge
    // ###########################################################################

    strobe_check: assert property (@(negedge clock) checking |-> (io_strobe == exp_strobe))
        else report_mismatch($sformatf("io_strobe %b, expected %b", io_strobe, exp_strobe));

    out_check: assert property (@(negedge clock) checking |-> (io_out == exp_io_out))
        else report_mismatch($sformatf("io_out %h, expected %h", io_out, exp_io_out));

    halted_check: assert property (@(negedge clock) checking |-> (halted == exp_halted))
        else report_mismatch($sformatf("halted %b, expected %b", halted, exp_halted));

    // Each strobe from the DUT retires the oldest expected OUT value
    always @(negedge clock)
    begin
        if (checking && io_strobe === 1'b1 && exp_q.size() > 0)
            void'(exp_q.pop_front());
    end

    initial
    begin
        io_in = '0;
        forever
        begin
            @(negedge clock);
            io_in = `DATA_WIDTH'($random(seed));
        end
    end

    initial
    begin
        rst_n      = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        checking   = 1'b0;
        exp_strobe = 1'b0;
        exp_halted = 1'b0;
        exp_io_out = '0;

        for (int p = 0; p < PROGRAM_COUNT; p++)
        begin
            build_program(p);
            reset_and_load();
            step_limit = 5 * count_instructions() + 50;
            fork
                run_model();
                watch_for_halt(step_limit);
            join
            repeat (HALT_HOLD) @(posedge clock); // Halted holds, strobe stays quiet
            checking = 1'b0;
        end

        if (exp_q.size() == 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
            stop_with_failure("expected OUT values were never produced");
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic clock
);

    initial
    begin
        clock = 1'b0;
        forever
            #50 clock = ~clock; // 100 ns period
    end

endmodule

// ==== rtl/mc16_cpu.sv ====
`timescale 1ns/10ps
`include "mc16_config.svh"

module mc16_cpu
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      load_en,
    input  logic [`MEM_ADDR_BITS-1:0] load_addr,
    input  logic [`DATA_WIDTH-1:0]    load_data,
    input  logic [`DATA_WIDTH-1:0]    io_in,
    output logic [`DATA_WIDTH-1:0]    io_out,
    output logic                      io_strobe,
    output logic                      halted
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    // Control
    logic    pc_write;
    logic    ir_write;
    logic    iord;
    src_a_t  src_a;
    src_b_t  src_b;
    alu_op_t alu_op;
    logic    branch;
    logic    mem_write;
    logic    reg_write;
    wb_sel_t wb_sel;
    logic    io_write;

    // Datapath
    instr_u                    instr;
    logic [`DATA_WIDTH-1:0]    pc;
    logic [`DATA_WIDTH-1:0]    pc_next;
    logic [`MEM_ADDR_BITS-1:0] mem_addr;
    logic [`DATA_WIDTH-1:0]    mem_rdata;
    logic [`DATA_WIDTH-1:0]    a_q;
    logic [`DATA_WIDTH-1:0]    b_q;
    logic [`DATA_WIDTH-1:0]    imm;
    logic [`DATA_WIDTH-1:0]    alu_out;
    logic [`DATA_WIDTH-1:0]    wb_data;
    logic                      branch_eq;

    cycle_controller i_cycle_controller
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .opcode    (instr.r.opcode),
        .branch_eq (branch_eq),
        .pc_write  (pc_write),
        .ir_write  (ir_write),
        .iord      (iord),
        .src_a     (src_a),
        .src_b     (src_b),
        .alu_op    (alu_op),
        .branch    (branch),
        .mem_write (mem_write),
        .reg_write (reg_write),
        .wb_sel    (wb_sel),
        .io_write  (io_write),
        .halted    (halted)
    );

    fetch_stage i_fetch_stage
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .pc_write  (pc_write),
        .ir_write  (ir_write),
        .iord      (iord),
        .pc_next   (pc_next),
        .alu_out   (alu_out),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .instr     (instr)
    );

    decode_stage i_decode_stage
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .instr     (instr),
        .reg_write (reg_write),
        .wb_data   (wb_data),
        .a_q       (a_q),
        .b_q       (b_q),
        .imm       (imm)
    );

    execute_stage i_execute_stage
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .pc        (pc),
        .a_q       (a_q),
        .b_q       (b_q),
        .imm       (imm),
        .src_a     (src_a),
        .src_b     (src_b),
        .alu_op    (alu_op),
        .branch    (branch),
        .alu_out   (alu_out),
        .pc_next   (pc_next),
        .branch_eq (branch_eq)
    );

    unified_memory i_unified_memory
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .addr      (mem_addr),
        .wdata     (b_q), // Store data comes from B
        .mem_write (mem_write),
        .rdata     (mem_rdata)
    );

    memory_stage i_memory_stage
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .alu_out   (alu_out),
        .a_q       (a_q),
        .io_in     (io_in),
        .wb_sel    (wb_sel),
        .io_write  (io_write),
        .wb_data   (wb_data),
        .io_out    (io_out),
        .io_strobe (io_strobe)
    );

endmodule

// ==== control/cycle_controller.sv ====
`timescale 1ns/10ps

module cycle_controller
(
    input  logic              clock,
    input  logic              rst_n,
    input  isa_pkg::opcode_t  opcode,
    input  logic              branch_eq,
    output logic              pc_write,
    output logic              ir_write,
    output logic              iord,
    output ctrl_pkg::src_a_t  src_a,
    output ctrl_pkg::src_b_t  src_b,
    output isa_pkg::alu_op_t  alu_op,
    output logic              branch,
    output logic              mem_write,
    output logic              reg_write,
    output ctrl_pkg::wb_sel_t wb_sel,
    output logic              io_write,
    output logic              halted
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    state_t state;
    state_t state_next;
    logic   is_rtype;

    assign is_rtype = (opcode == ADD) || (opcode == SUB) || (opcode == AND) || (opcode == OR);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            state <= FETCH;
        else
            state <= state_next;
    end

    // ###########################################################################
    // Per-state outputs and sequencing
    // ###########################################################################

    always_comb
    begin
        state_next = state;
        pc_write   = 1'b0;
        ir_write   = 1'b0;
        iord       = 1'b0;
        src_a      = SRC_A_PC;
        src_b      = SRC_B_ONE;
        alu_op     = ALU_ADD;
        branch     = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        wb_sel     = WB_ALU;
        io_write   = 1'b0;
        halted     = 1'b0;

        case (state)
            FETCH:
            begin
                ir_write   = 1'b1;
                pc_write   = 1'b1; // PC + 1 through the ALU
                state_next = DECODE;
            end
            DECODE:
            begin
                if (is_rtype || opcode == ADDI || opcode == LW || opcode == SW ||
                    opcode == BEQ)
                    state_next = EXEC;
                else if (opcode == IN)
                    state_next = WB;
                else if (opcode == OUT)
                    state_next = MEM;
                else
                    state_next = HALTED;
            end
            EXEC:
            begin
                src_a = SRC_A_REG;
                src_b = is_rtype || opcode == BEQ ? SRC_B_REG : SRC_B_IMM;
                case (opcode)
                    SUB, BEQ: alu_op = ALU_SUB;
                    AND:      alu_op = ALU_AND;
                    OR:       alu_op = ALU_OR;
                    default:  alu_op = ALU_ADD;
                endcase
                if (opcode == BEQ)
                begin
                    branch     = 1'b1;
                    pc_write   = branch_eq;
                    state_next = FETCH;
                end
                else if (opcode == LW || opcode == SW)
                    state_next = MEM;
                else
                    state_next = WB;
            end
            MEM:
            begin
                iord       = 1'b1;
                mem_write  = opcode == SW;
                io_write   = opcode == OUT;
                state_next = opcode == LW ? WB : FETCH;
            end
            WB:
            begin
                reg_write = 1'b1;
                if (opcode == LW)
                    wb_sel = WB_MDR;
                else if (opcode == IN)
                    wb_sel = WB_IO;
                state_next = FETCH;
            end
            default:
                halted = 1'b1; // Parked until reset
        endcase
    end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/10ps
`include "mc16_config.svh"

module memory_stage
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`DATA_WIDTH-1:0] mem_rdata,
    input  logic [`DATA_WIDTH-1:0] alu_out,
    input  logic [`DATA_WIDTH-1:0] a_q,
    input  logic [`DATA_WIDTH-1:0] io_in,
    input  ctrl_pkg::wb_sel_t      wb_sel,
    input  logic                   io_write,
    output logic [`DATA_WIDTH-1:0] wb_data,
    output logic [`DATA_WIDTH-1:0] io_out,
    output logic                   io_strobe
);
    import ctrl_pkg::*;

    logic [`DATA_WIDTH-1:0] mdr;

    always_ff @(posedge clock)
    begin
        mdr <= mem_rdata;
    end

    // OUT drives rs1 from A, strobe follows one cycle later
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            io_out    <= '0;
            io_strobe <= 1'b0;
        end
        else
        begin
            if (io_write)
                io_out <= a_q;
            io_strobe <= io_write;
        end
    end

    always_comb
    begin
        case (wb_sel)
            WB_MDR:  wb_data = mdr;
            WB_IO:   wb_data = io_in;
            default: wb_data = alu_out;
        endcase
    end

endmodule

// ==== rtl/unified_memory.sv ====
`timescale 1ns/10ps
`include "mc16_config.svh"

module unified_memory
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      load_en,
    input  logic [`MEM_ADDR_BITS-1:0] load_addr,
    input  logic [`DATA_WIDTH-1:0]    load_data,
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  logic [`DATA_WIDTH-1:0]    wdata,
    input  logic                      mem_write,
    output logic [`DATA_WIDTH-1:0]    rdata
);

    logic [`DATA_WIDTH-1:0] ram [2**`MEM_ADDR_BITS];

    // ###########################################################################
    // Single write port, shared between program load and stores
    // ###########################################################################

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            if (load_en)
                ram[load_addr] <= load_data;
        end
        else if (mem_write)
            ram[addr] <= wdata;
    end

    assign rdata = ram[addr]; // Asynchronous read

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/10ps
`include "mc16_config.svh"

module execute_stage
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`DATA_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] a_q,
    input  logic [`DATA_WIDTH-1:0] b_q,
    input  logic [`DATA_WIDTH-1:0] imm,
    input  ctrl_pkg::src_a_t       src_a,
    input  ctrl_pkg::src_b_t       src_b,
    input  isa_pkg::alu_op_t       alu_op,
    input  logic                   branch,
    output logic [`DATA_WIDTH-1:0] alu_out,
    output logic [`DATA_WIDTH-1:0] pc_next,
    output logic                   branch_eq
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [`DATA_WIDTH-1:0] opnd_a;
    logic [`DATA_WIDTH-1:0] opnd_b;
    logic [`DATA_WIDTH-1:0] alu_result;

    assign opnd_a = src_a == SRC_A_PC ? pc : a_q;

    always_comb
    begin
        case (src_b)
            SRC_B_ONE: opnd_b = `DATA_WIDTH'(1);
            SRC_B_IMM: opnd_b = imm;
            default:   opnd_b = b_q;
        endcase
    end

    always_comb
    begin
        case (alu_op)
            ALU_SUB: alu_result = opnd_a - opnd_b;
            ALU_AND: alu_result = opnd_a & opnd_b;
            ALU_OR:  alu_result = opnd_a | opnd_b;
            default: alu_result = opnd_a + opnd_b; // Wraps at 16 bits
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            alu_out <= '0;
        else
            alu_out <= alu_result;
    end

    // PC already points past the BEQ here
    assign pc_next   = branch ? pc + imm : alu_result;
    assign branch_eq = a_q == b_q;

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/10ps
`include "mc16_config.svh"

module decode_stage
(
    input  logic                   clock,
    input  logic                   rst_n,
    input  isa_pkg::instr_u        instr,
    input  logic                   reg_write,
    input  logic [`DATA_WIDTH-1:0] wb_data,
    output logic [`DATA_WIDTH-1:0] a_q,
    output logic [`DATA_WIDTH-1:0] b_q,
    output logic [`DATA_WIDTH-1:0] imm
);
    import isa_pkg::*;

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [3:0]             rb_addr;

    // R-type reads rs2, everything else reads rd on the second port
    always_comb
    begin
        case (instr.r.opcode)
            ADD, SUB, AND, OR: rb_addr = instr.r.rs2;
            default:           rb_addr = instr.r.rd;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (reg_write)
            regs[instr.r.rd] <= wb_data;
    end

    always_ff @(posedge clock)
    begin
        a_q <= regs[instr.r.rs1];
        b_q <= regs[rb_addr];
    end

    assign imm = {{(`DATA_WIDTH-4){instr.i.imm4[3]}}, instr.i.imm4};

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/10ps
`include "mc16_config.svh"

module fetch_stage
(
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      pc_write,
    input  logic                      ir_write,
    input  logic                      iord,
    input  logic [`DATA_WIDTH-1:0]    pc_next,
    input  logic [`DATA_WIDTH-1:0]    alu_out,
    input  logic [`DATA_WIDTH-1:0]    mem_rdata,
    output logic [`DATA_WIDTH-1:0]    pc,
    output logic [`MEM_ADDR_BITS-1:0] mem_addr,
    output isa_pkg::instr_u           instr
);

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            pc <= `DATA_WIDTH'(`RESET_PC);
        else if (pc_write)
            pc <= pc_next;
    end

    always_ff @(posedge clock)
    begin
        if (ir_write)
            instr <= mem_rdata;
    end

    // Data accesses use the address left in ALUOut
    assign mem_addr = iord ? alu_out[`MEM_ADDR_BITS-1:0] : pc[`MEM_ADDR_BITS-1:0];

endmodule

// ==== common/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [2:0]
    {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WB,
        HALTED
    } state_t;

    typedef enum logic
    {
        SRC_A_PC,
        SRC_A_REG
    } src_a_t;

    typedef enum logic [1:0]
    {
        SRC_B_REG,
        SRC_B_ONE,
        SRC_B_IMM
    } src_b_t;

    typedef enum logic [1:0]
    {
        WB_ALU,
        WB_MDR,
        WB_IO
    } wb_sel_t;

endpackage

// ==== common/isa_pkg.sv ====
package isa_pkg;

    // ###########################################################################
    // Instruction encoding
    // ###########################################################################

    typedef enum logic [3:0]
    {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        ADDI = 4'd4,
        LW   = 4'd5,
        SW   = 4'd6,
        BEQ  = 4'd7,
        IN   = 4'd8,
        OUT  = 4'd9,
        HALT = 4'd15 // Unused codes behave the same
    } opcode_t;

    typedef struct packed
    {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
    } r_fields_t;

    typedef struct packed
    {
        opcode_t           opcode;
        logic [3:0]        rd;   // Store data register for SW
        logic [3:0]        rs1;
        logic signed [3:0] imm4;
    } i_fields_t;

    // One IR word seen through either field layout
    typedef union packed
    {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    typedef enum logic [1:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

endpackage

// ==== common/mc16_config.svh ====
`ifndef MC16_CONFIG_SVH
`define MC16_CONFIG_SVH

// ###########################################################################
// Processor sizing
// ###########################################################################

`define DATA_WIDTH    16
`define REG_COUNT     16
`define MEM_ADDR_BITS 8 // 256 words
`define RESET_PC      0

`endif
